// File: src.f
design/fetch_pkg.sv
design/fetch_ctrl_fsm.sv
design/fetch_addr_cnt.sv
design/fetch_fifo.sv
design/prefetch_buffer.sv
verification/tb_prefetch_buffer.sv

// File: run.sh
#!/bin/sh
# build and run the prefetch buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_prefetch_buffer -f src.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_prefetch_buffer > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi

// File: verification/tb_prefetch_buffer.sv
// testbench of the instruction prefetch buffer
// LFSR stimulus, memory model with random grant and rvalid delays, reference model and checks
`timescale 1ns/1ps

module tb_prefetch_buffer;

  import fetch_pkg::*;

  localparam int          TEST_CYCLES    = 3000;
  localparam int          TIMEOUT_CYCLES = 4000;
  localparam int          HOLD_START     = 1000;
  localparam int          HOLD_END       = 1300;
  localparam logic [31:0] DATA_MASK      = 32'hA5A5_0F0F;
  localparam logic [31:0] BRANCH_BASE    = 32'h0000_1000;

  logic        clk_i          = 1'b0;
  logic        rst_ni;
  logic        req_i          = 1'b0;
  logic        branch_i       = 1'b0;
  logic [31:0] branch_addr_i  = '0;
  logic        ready_i        = 1'b0;
  logic        instr_gnt_i    = 1'b0;
  logic [31:0] instr_rdata_i  = '0;
  logic        instr_rvalid_i = 1'b0;
  logic        valid_o;
  logic        busy_o;
  logic        instr_req_o;
  logic [31:0] rdata_o;
  logic [31:0] addr_o;
  logic [31:0] instr_addr_o;

  // random source and run control
  logic [31:0] lfsr_q    = 32'h9915;
  int          cycle_cnt = 0;
  logic        started   = 1'b0;
  logic        run_done  = 1'b0;
  // memory model
  logic        mem_pending = 1'b0;
  logic        mem_stale   = 1'b0;
  logic [31:0] mem_addr    = '0;
  logic [1:0]  rv_wait     = '0;
  logic [1:0]  gnt_wait    = '0;
  // reference model
  logic [31:0] exp_addr    = '0;
  int          occ         = 0;
  int          max_occ     = 0;
  int          accepted    = 0;
  logic        branch_seen = 1'b0;
  logic        hold_req    = 1'b0;
  logic [31:0] hold_addr   = '0;

  prefetch_buffer prefetch_buffer_i (
    .clk_i, .rst_ni, .req_i, .branch_i, .branch_addr_i, .ready_i, .valid_o, .rdata_o,
    .addr_o, .busy_o, .instr_req_o, .instr_gnt_i, .instr_addr_o, .instr_rdata_i,
    .instr_rvalid_i
  );

  always #4 clk_i = ~clk_i;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic stop_on_fault(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic stop_on_mismatch(input string test, input logic [31:0] exp,
                                  input logic [31:0] act);
    stop_on_fault($sformatf("ERROR %s: expected %h, actual %h", test, exp, act));
  endtask

  ////////////////////////////////////////
  // memory model, reference model, stimulus
  ////////////////////////////////////////

  always @(posedge clk_i) begin : model_blk
    logic [31:0] rnd;
    logic        live;
    cycle_cnt = cycle_cnt + 1;
    assert (cycle_cnt < TIMEOUT_CYCLES)
      else stop_on_fault("timeout, the DUT did not drain within the cycle limit");
    if (rst_ni) begin
      // an ungranted request keeps its address unless a branch retargets it
      if (hold_req) begin
        assert (instr_req_o) else stop_on_fault("instr_req_o dropped before grant");
        if (!branch_i) begin
          assert (instr_addr_o == hold_addr)
            else stop_on_mismatch("addr_hold", hold_addr, instr_addr_o);
        end
      end
      hold_req  = instr_req_o && !instr_gnt_i && !branch_i;
      hold_addr = instr_addr_o;
      // busy while a request is driven or a granted response is still owed
      assert (busy_o == (instr_req_o || mem_pending))
        else stop_on_mismatch("busy", {31'd0, instr_req_o || mem_pending}, {31'd0, busy_o});
      if (branch_seen) begin
        assert (!valid_o) else stop_on_mismatch("branch_flush", 32'd0, {31'd0, valid_o});
      end
      assert (valid_o == (occ != 0))
        else stop_on_mismatch("fifo_valid", {31'd0, occ != 0}, {31'd0, valid_o});
      // consumer pop
      if (valid_o && ready_i) begin
        assert (addr_o == exp_addr) else stop_on_mismatch("addr_sequence", exp_addr, addr_o);
        assert (rdata_o == (addr_o ^ DATA_MASK))
          else stop_on_mismatch("data_pairing", addr_o ^ DATA_MASK, rdata_o);
        exp_addr = exp_addr + WORD_BYTES;
        occ      = occ - 1;
        accepted = accepted + 1;
      end
      // a response is live unless a branch came after its grant
      live = instr_rvalid_i && !mem_stale && !branch_i;
      if (instr_rvalid_i) begin
        mem_pending = 1'b0;
        mem_stale   = 1'b0;
      end
      branch_seen = branch_i;
      if (branch_i) begin
        occ      = 0;
        exp_addr = branch_addr_i;
        if (mem_pending) begin
          mem_stale = 1'b1;
        end
      end
      if (live) begin
        occ = occ + 1;
      end
      if (occ > max_occ) begin
        max_occ = occ;
      end
      assert (occ <= int'(FIFO_DEPTH))
        else stop_on_mismatch("fifo_depth", 32'(FIFO_DEPTH), 32'(occ));
      // grant starts a transfer, rvalid follows one to four cycles later
      if (instr_req_o && instr_gnt_i) begin
        assert (!mem_pending) else stop_on_fault("second request granted while one is outstanding");
        mem_pending = 1'b1;
        mem_stale   = 1'b0;
        mem_addr    = instr_addr_o;
        draw_bits(2, rnd);
        rv_wait = rnd[1:0];
        draw_bits(2, rnd);
        gnt_wait = rnd[1:0];
      end else begin
        if (mem_pending && rv_wait != 2'd0) begin
          rv_wait = rv_wait - 2'd1;
        end
        if (instr_req_o && gnt_wait != 2'd0) begin
          gnt_wait = gnt_wait - 2'd1;
        end
      end
      instr_rvalid_i <= mem_pending && (rv_wait == 2'd0);
      instr_rdata_i  <= mem_addr ^ DATA_MASK;
      instr_gnt_i    <= (gnt_wait == 2'd0);
      // core side
      if (cycle_cnt >= TEST_CYCLES) begin
        // drain with no new fetches
        req_i    <= 1'b0;
        branch_i <= 1'b0;
        ready_i  <= 1'b1;
        if (cycle_cnt > TEST_CYCLES + 2 && !busy_o && !valid_o && !mem_pending) begin
          run_done <= 1'b1;
        end
      end else begin
        req_i <= 1'b1;
        draw_bits(2, rnd);
        // ready held low for a while so the FIFO fills
        ready_i <= (cycle_cnt < HOLD_START || cycle_cnt >= HOLD_END) && (rnd[1:0] != 2'd0);
        draw_bits(5, rnd);
        branch_i <= !started ||
                    ((rnd[4:0] == 5'd0) && (cycle_cnt < HOLD_START || cycle_cnt >= HOLD_END));
        draw_bits(6, rnd);
        branch_addr_i <= BRANCH_BASE + {24'd0, rnd[5:0], 2'b00};
        started = 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // reset and end of run
  ////////////////////////////////////////

  initial begin
    rst_ni = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert (!valid_o && !instr_req_o && !busy_o)
      else stop_on_mismatch("reset_state", 32'd0, {29'd0, valid_o, instr_req_o, busy_o});
    wait (run_done);
    assert (accepted > 0) else stop_on_fault("no instruction word was accepted");
    assert (max_occ == int'(FIFO_DEPTH))
      else stop_on_mismatch("fifo_fill", 32'(FIFO_DEPTH), 32'(max_occ));
    assert (occ == 0) else stop_on_mismatch("drain", 32'd0, 32'(occ));
    $display("All checks passed");
    $finish;
  end

endmodule

// File: design/prefetch_buffer.sv
// instruction prefetch buffer top level
// fetch FSM, address counter and FIFO between the core and instruction memory
`timescale 1ns/1ps

module prefetch_buffer (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // core side
  input  logic                         req_i,
  input  logic                         branch_i,
  input  logic [fetch_pkg::ADDR_W-1:0] branch_addr_i,
  input  logic                         ready_i,
  output logic                         valid_o,
  output logic [fetch_pkg::DATA_W-1:0] rdata_o,
  output logic [fetch_pkg::ADDR_W-1:0] addr_o,
  output logic                         busy_o,
  // instruction memory side
  output logic                         instr_req_o,
  input  logic                         instr_gnt_i,
  output logic [fetch_pkg::ADDR_W-1:0] instr_addr_o,
  input  logic [fetch_pkg::DATA_W-1:0] instr_rdata_i,
  input  logic                         instr_rvalid_i
);

  import fetch_pkg::*;

  logic                  fifo_space;
  logic                  fifo_push;
  logic                  fifo_pop;
  logic                  addr_load;
  logic                  fsm_active;
  logic [ADDR_SEL_W-1:0] addr_sel;
  logic [ADDR_W-1:0]     cur_addr;

  // busy while a request is driven or a response is owed
  assign busy_o   = fsm_active | instr_req_o;
  // a word leaves only when presented and accepted
  assign fifo_pop = valid_o & ready_i;

  fetch_ctrl_fsm fetch_ctrl_fsm_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .space_i        (fifo_space),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_req_o    (instr_req_o),
    .addr_load_o    (addr_load),
    .push_o         (fifo_push),
    .active_o       (fsm_active),
    .addr_sel_o     (addr_sel)
  );

  fetch_addr_cnt fetch_addr_cnt_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .load_i        (addr_load),
    .addr_sel_i    (addr_sel),
    .branch_addr_i (branch_addr_i),
    .cur_addr_o    (cur_addr),
    .next_addr_o   (),
    .fetch_addr_o  (instr_addr_o)
  );

  // responses pair with the address of the outstanding request
  fetch_fifo fetch_fifo_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (branch_i),
    .push_i     (fifo_push),
    .pop_i      (fifo_pop),
    .in_addr_i  (cur_addr),
    .in_data_i  (instr_rdata_i),
    .valid_o    (valid_o),
    .space_o    (fifo_space),
    .out_addr_o (addr_o),
    .out_data_o (rdata_o)
  );

endmodule

// File: design/fetch_fifo.sv
// shift-style FIFO of fetched address/data pairs
// clear, push and pop, plus a space flag that covers the word in flight
`timescale 1ns/1ps

module fetch_fifo (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  logic                         push_i,
  input  logic                         pop_i,
  input  logic [fetch_pkg::ADDR_W-1:0] in_addr_i,
  input  logic [fetch_pkg::DATA_W-1:0] in_data_i,
  output logic                         valid_o,
  output logic                         space_o,
  output logic [fetch_pkg::ADDR_W-1:0] out_addr_o,
  output logic [fetch_pkg::DATA_W-1:0] out_data_o
);

  import fetch_pkg::*;

  // entry 0 is the head
  logic [ADDR_W-1:0]     addr_q [FIFO_DEPTH];
  logic [ADDR_W-1:0]     addr_d [FIFO_DEPTH];
  logic [DATA_W-1:0]     data_q [FIFO_DEPTH];
  logic [DATA_W-1:0]     data_d [FIFO_DEPTH];
  logic [FIFO_CNT_W-1:0] cnt_q, cnt_d;
  logic [FIFO_CNT_W-1:0] wr_idx;

  ////////////////////////////////////////
  // status
  ////////////////////////////////////////

  assign valid_o    = (cnt_q != '0);
  // two free entries: one for the next request, one for the word in flight
  assign space_o    = (cnt_q < FIFO_CNT_W'(FIFO_DEPTH - 1));
  assign out_addr_o = addr_q[0];
  assign out_data_o = data_q[0];

  // a pop shifts everything down, so the tail slot moves with it
  assign wr_idx = cnt_q - FIFO_CNT_W'(pop_i);

  ////////////////////////////////////////
  // next contents
  ////////////////////////////////////////

  always_comb begin
    addr_d = addr_q;
    data_d = data_q;
    if (pop_i) begin
      for (int i = 0; i < FIFO_DEPTH - 1; i++) begin
        addr_d[i] = addr_q[i+1];
        data_d[i] = data_q[i+1];
      end
    end
    if (push_i) begin
      addr_d[wr_idx] = in_addr_i;
      data_d[wr_idx] = in_data_i;
    end
  end

  // clear wins over push and pop
  always_comb begin
    if (clear_i) begin
      cnt_d = '0;
    end else begin
      cnt_d = cnt_q + FIFO_CNT_W'(push_i) - FIFO_CNT_W'(pop_i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // payload storage
  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    data_q <= data_d;
  end

  // the FSM only fetches ahead while space_o holds, so a push always fits
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i && !clear_i |-> (cnt_q < FIFO_CNT_W'(FIFO_DEPTH)))
    else $error("push into full FIFO");

  // consumer pops only a presented word
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> valid_o)
    else $error("pop from empty FIFO");

endmodule

// File: design/fetch_addr_cnt.sv
// fetch address register and next-word incrementer
// forms the memory address from the FSM select
`timescale 1ns/1ps

module fetch_addr_cnt (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             load_i,
  input  logic [fetch_pkg::ADDR_SEL_W-1:0] addr_sel_i,
  input  logic [fetch_pkg::ADDR_W-1:0]     branch_addr_i,
  output logic [fetch_pkg::ADDR_W-1:0]     cur_addr_o,
  output logic [fetch_pkg::ADDR_W-1:0]     next_addr_o,
  output logic [fetch_pkg::ADDR_W-1:0]     fetch_addr_o
);

  import fetch_pkg::*;

  // address of the outstanding or last request
  logic [ADDR_W-1:0] addr_q;

  assign cur_addr_o  = addr_q;
  // step from the word-aligned address
  assign next_addr_o = {addr_q[ADDR_W-1:2], 2'b00} + ADDR_W'(WORD_BYTES);

  // address mux toward memory
  always_comb begin
    case (addr_sel_i)
      ADDR_SEL_BRANCH: fetch_addr_o = branch_addr_i;
      ADDR_SEL_CUR:    fetch_addr_o = addr_q;
      default:         fetch_addr_o = next_addr_o;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (load_i) begin
      addr_q <= fetch_addr_o;
    end
  end

  // the core only branches to word-aligned targets
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_i && (addr_sel_i == ADDR_SEL_BRANCH) |-> (branch_addr_i[1:0] == 2'b00))
    else $error("misaligned branch target %h", branch_addr_i);

endmodule

// File: design/fetch_ctrl_fsm.sv
// fetch control FSM of the prefetch buffer
// drives the memory request, the address select, the counter load and the FIFO push
`timescale 1ns/1ps

module fetch_ctrl_fsm (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             req_i,
  input  logic                             branch_i,
  input  logic                             space_i,
  input  logic                             instr_gnt_i,
  input  logic                             instr_rvalid_i,
  output logic                             instr_req_o,
  output logic                             addr_load_o,
  output logic                             push_o,
  output logic                             active_o,
  output logic [fetch_pkg::ADDR_SEL_W-1:0] addr_sel_o
);

  import fetch_pkg::*;

  fetch_state_e state_q, state_d;
  logic         can_issue;

  // a branch clears the FIFO, so it always makes room for a new fetch
  assign can_issue = req_i & (space_i | branch_i);

  // high while a request is pending or a response is owed
  assign active_o = (state_q != IDLE);

  ////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    instr_req_o = 1'b0;
    addr_load_o = 1'b0;
    push_o      = 1'b0;
    // a branch target always takes priority on the address mux
    addr_sel_o  = branch_i ? ADDR_SEL_BRANCH : ADDR_SEL_NEXT;

    unique case (state_q)
      // nothing outstanding
      IDLE: begin
        if (can_issue) begin
          instr_req_o = 1'b1;
          addr_load_o = 1'b1;
          state_d     = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
        end
      end

      // request held with a stable address until granted
      WAIT_GNT: begin
        instr_req_o = 1'b1;
        if (!branch_i) begin
          addr_sel_o = ADDR_SEL_CUR;
        end
        // ungranted request, so a branch may simply retarget it
        addr_load_o = branch_i;
        state_d     = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
      end

      // granted, waiting for the word
      WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          // with a branch in the same cycle the FIFO clear drops this word
          push_o = 1'b1;
          if (can_issue) begin
            // back-to-back fetch of the following word
            instr_req_o = 1'b1;
            addr_load_o = 1'b1;
            state_d     = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
          end else begin
            state_d = IDLE;
          end
        end else if (branch_i) begin
          // response still owed; remember the target and drain it first
          addr_load_o = 1'b1;
          state_d     = WAIT_ABORTED;
        end
      end

      // stale response in flight, target already stored in the counter
      // the core keeps req_i high across a branch
      WAIT_ABORTED: begin
        if (!branch_i) begin
          addr_sel_o = ADDR_SEL_CUR;
        end
        // a further branch just replaces the stored target
        addr_load_o = branch_i;
        if (instr_rvalid_i) begin
          // stale word is not pushed, the target is requested instead
          instr_req_o = 1'b1;
          state_d     = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  ////////////////////////////////////////
  // state register
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // an ungranted request never falls back
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o)
    else $error("instr_req_o dropped before grant");

  // a branch with a response still owed moves to draining and pushes nothing
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == WAIT_RVALID) && branch_i && !instr_rvalid_i
      |=> (state_q == WAIT_ABORTED) && !push_o)
    else $error("stale response not dropped in state %s", state_q.name());

endmodule

// File: design/fetch_pkg.sv
// shared definitions of the instruction prefetch buffer
// fetch FSM states, bus widths, FIFO sizing and address select codes
package fetch_pkg;

  ////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////

  // instruction address and word width
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // byte step between sequential word fetches
  localparam int unsigned WORD_BYTES = 4;

  ////////////////////////////////////////
  // FIFO sizing
  ////////////////////////////////////////

  localparam int unsigned FIFO_DEPTH = 3;
  // occupancy count, holds 0 to FIFO_DEPTH
  localparam int unsigned FIFO_CNT_W = 2;

  ////////////////////////////////////////
  // fetch address select
  ////////////////////////////////////////

  localparam int unsigned ADDR_SEL_W = 2;
  // branch target, next sequential word, or replay of the held address
  localparam logic [ADDR_SEL_W-1:0] ADDR_SEL_BRANCH = 2'd0;
  localparam logic [ADDR_SEL_W-1:0] ADDR_SEL_NEXT   = 2'd1;
  localparam logic [ADDR_SEL_W-1:0] ADDR_SEL_CUR    = 2'd2;

  // fetch FSM states
  // wait_aborted drains a response that a branch made stale
  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    WAIT_ABORTED
  } fetch_state_e;

endpackage
